// File: all.f
+incdir+.
cart_pkg.sv
snes_bus_sync.sv
mcu_req_regs.sv
rom_arbiter.sv
rom_port.sv
cart_main.sv
tb_cart_main.sv

// File: cart_consts.svh
`ifndef CART_CONSTS_SVH
`define CART_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

`define ROM_AW      24  // Byte address
`define ROM_WORD_AW 23  // PSRAM word address
`define DATA_W      8
`define ROM_DW      16  // PSRAM data bus

////////////////////////////////////////////////////////////////////////////
// Timing
////////////////////////////////////////////////////////////////////////////

// Delay count, access lasts one cycle longer
`define ROM_CYCLE_LEN     4'd7
// About 1 ms of CLK2 without a console clock change
`define SNES_DEAD_TIMEOUT 18'd88000
`define CPU_SYNC_LEN      5

`endif

// File: cart_main.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module cart_main (
  input  logic                    CLK2,
  input  logic                    arst_n,
  // Console bus
  input  logic                    snes_cpu_clk,
  input  logic [`ROM_AW-1:0]      snes_addr,
  input  logic                    snes_romsel_n,
  input  logic [`ROM_AW-1:0]      rom_mask,
  output logic [`DATA_W-1:0]      snes_rdata,
  // MCU
  input  logic                    mcu_req,
  input  logic                    mcu_we,
  input  cart_pkg::rom_addr_u     mcu_addr,
  input  logic [`DATA_W-1:0]      mcu_wdata,
  output logic                    mcu_ack,
  output logic [`DATA_W-1:0]      mcu_rdata,
  // PSRAM
  output logic [`ROM_WORD_AW-1:0] rom_addr,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  output logic                    rom_we_n,
  output logic [`ROM_DW-1:0]      rom_dq_out,
  output logic                    rom_dq_oe,
  input  logic [`ROM_DW-1:0]      rom_dq_in
);

  logic                 cycle_start;
  logic                 cycle_end;
  logic                 cpu_clk_change;
  logic                 snes_dead;
  logic                 start_rd;
  logic                 start_wr;
  cart_pkg::rom_addr_u  req_addr;
  logic [`DATA_W-1:0]   req_wdata;
  cart_pkg::arb_state_e arb_state;
  logic                 acc_done;
  logic                 rd_sample;
  logic [`DATA_W-1:0]   rd_byte;

  snes_bus_sync snes_bus_sync_i (
    .CLK2           (CLK2),
    .arst_n         (arst_n),
    .snes_cpu_clk   (snes_cpu_clk),
    .cycle_start    (cycle_start),
    .cycle_end      (cycle_end),
    .cpu_clk_change (cpu_clk_change),
    .snes_dead      (snes_dead)
  );

  mcu_req_regs mcu_req_regs_i (
    .CLK2      (CLK2),
    .arst_n    (arst_n),
    .mcu_req   (mcu_req),
    .mcu_we    (mcu_we),
    .mcu_addr  (mcu_addr),
    .mcu_wdata (mcu_wdata),
    .mcu_ack   (mcu_ack),
    .mcu_rdata (mcu_rdata),
    .start_rd  (start_rd),
    .start_wr  (start_wr),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .acc_done  (acc_done),
    .rd_sample (rd_sample),
    .rd_byte   (rd_byte)
  );

  rom_arbiter rom_arbiter_i (
    .CLK2           (CLK2),
    .arst_n         (arst_n),
    .start_rd       (start_rd),
    .start_wr       (start_wr),
    .cycle_start    (cycle_start),
    .cycle_end      (cycle_end),
    .cpu_clk_change (cpu_clk_change),
    .snes_dead      (snes_dead),
    .snes_romsel_n  (snes_romsel_n),
    .state          (arb_state),
    .acc_done       (acc_done),
    .rd_sample      (rd_sample)
  );

  rom_port rom_port_i (
    .state      (arb_state),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .snes_addr  (snes_addr),
    .rom_mask   (rom_mask),
    .rom_addr   (rom_addr),
    .rom_bhe_n  (rom_bhe_n),
    .rom_ble_n  (rom_ble_n),
    .rom_we_n   (rom_we_n),
    .rom_dq_out (rom_dq_out),
    .rom_dq_oe  (rom_dq_oe),
    .rom_dq_in  (rom_dq_in),
    .rd_byte    (rd_byte),
    .snes_rdata (snes_rdata)
  );

endmodule

// File: cart_pkg.sv
`include "cart_consts.svh"

package cart_pkg;

  // PSRAM view of a byte address
  typedef struct packed {
    logic [`ROM_WORD_AW-1:0] word;
    logic                    lane;  // Set selects the low byte
  } rom_word_lane_s;

  // One byte address, read flat or split into word and lane
  typedef union packed {
    logic [`ROM_AW-1:0] flat;
    rom_word_lane_s     wl;
  } rom_addr_u;

  // Access sequencer states
  typedef enum logic [2:0] {
    idle        = 3'd0,
    mcu_rd_addr = 3'd1,
    mcu_rd_end  = 3'd2,
    mcu_wr_addr = 3'd3,
    mcu_wr_end  = 3'd4
  } arb_state_e;

endpackage

// File: mcu_req_regs.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module mcu_req_regs (
  input  logic                 CLK2,
  input  logic                 arst_n,
  // MCU side
  input  logic                 mcu_req,
  input  logic                 mcu_we,
  input  cart_pkg::rom_addr_u  mcu_addr,
  input  logic [`DATA_W-1:0]   mcu_wdata,
  output logic                 mcu_ack,
  output logic [`DATA_W-1:0]   mcu_rdata,
  // Arbiter side
  output logic                 start_rd,
  output logic                 start_wr,
  output cart_pkg::rom_addr_u  req_addr,
  output logic [`DATA_W-1:0]   req_wdata,
  input  logic                 acc_done,
  input  logic                 rd_sample,
  input  logic [`DATA_W-1:0]   rd_byte
);

  logic req_taken;  // Current req level already latched
  logic accept;

  // New request only when nothing is outstanding and ack is low
  assign accept = mcu_req & ~req_taken & ~mcu_ack & ~start_rd & ~start_wr;

  ////////////////////////////////////////////////////////////////////////////
  // Request and handshake control
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      req_taken <= 1'b0;
      start_rd  <= 1'b0;
      start_wr  <= 1'b0;
      mcu_ack   <= 1'b0;
    end else begin
      // Pending flags
      if (accept) begin
        start_rd <= ~mcu_we;
        start_wr <= mcu_we;
      end else if (acc_done) begin
        start_rd <= 1'b0;
        start_wr <= 1'b0;
      end

      // Rearm once the MCU lets go of req
      if (!mcu_req) begin
        req_taken <= 1'b0;
      end else if (accept) begin
        req_taken <= 1'b1;
      end

      if (acc_done) begin
        mcu_ack <= 1'b1;
      end else if (!mcu_req) begin
        mcu_ack <= 1'b0;  // Ack half of four-phase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Address and data registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2) begin
    if (accept) begin
      req_addr  <= mcu_addr;
      req_wdata <= mcu_wdata;
    end
    if (rd_sample) begin
      mcu_rdata <= rd_byte;  // Last cycle of the read window
    end
  end

endmodule

// File: rom_arbiter.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module rom_arbiter (
  input  logic                 CLK2,
  input  logic                 arst_n,
  // Pending MCU access
  input  logic                 start_rd,
  input  logic                 start_wr,
  // Console bus timing
  input  logic                 cycle_start,
  input  logic                 cycle_end,
  input  logic                 cpu_clk_change,
  input  logic                 snes_dead,
  input  logic                 snes_romsel_n,
  // Access sequencing
  output cart_pkg::arb_state_e state,
  output logic                 acc_done,
  output logic                 rd_sample
);

  logic [3:0] delay_cnt;
  logic       free_slot;
  logic       can_grant;

  // The ROM is free after a cycle ends, or during a cycle that
  // does not touch ROM
  assign free_slot = cycle_end | (cycle_start & snes_romsel_n);
  assign can_grant = free_slot | snes_dead;

  ////////////////////////////////////////////////////////////////////////////
  // State machine
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      state     <= cart_pkg::idle;
      delay_cnt <= '0;
    end else if (snes_dead & cpu_clk_change) begin
      // Console woke up in the middle of a free-running access.
      // Drop it, the pending flag is still set so it starts over.
      state <= cart_pkg::idle;
    end else begin
      case (state)
        cart_pkg::idle: begin
          if (can_grant) begin
            if (start_rd) begin
              state     <= cart_pkg::mcu_rd_addr;
              delay_cnt <= `ROM_CYCLE_LEN;
            end else if (start_wr) begin
              state     <= cart_pkg::mcu_wr_addr;
              delay_cnt <= `ROM_CYCLE_LEN;
            end
          end
        end

        cart_pkg::mcu_rd_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == 4'd0) begin
            state <= cart_pkg::mcu_rd_end;
          end
        end

        cart_pkg::mcu_wr_addr: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == 4'd0) begin
            state <= cart_pkg::mcu_wr_end;
          end
        end

        cart_pkg::mcu_rd_end,
        cart_pkg::mcu_wr_end: begin
          state <= cart_pkg::idle;
        end

        default: begin
          state <= cart_pkg::idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobes to the request block
  ////////////////////////////////////////////////////////////////////////////

  assign acc_done = (state == cart_pkg::mcu_rd_end) |
                    (state == cart_pkg::mcu_wr_end);

  // PSRAM data has settled by the last address cycle
  assign rd_sample = (state == cart_pkg::mcu_rd_addr) & (delay_cnt == 4'd0);

endmodule

// File: rom_port.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module rom_port (
  input  cart_pkg::arb_state_e    state,
  // MCU access
  input  cart_pkg::rom_addr_u     req_addr,
  input  logic [`DATA_W-1:0]      req_wdata,
  // Console address
  input  logic [`ROM_AW-1:0]      snes_addr,
  input  logic [`ROM_AW-1:0]      rom_mask,
  // PSRAM
  output logic [`ROM_WORD_AW-1:0] rom_addr,
  output logic                    rom_bhe_n,
  output logic                    rom_ble_n,
  output logic                    rom_we_n,
  output logic [`ROM_DW-1:0]      rom_dq_out,
  output logic                    rom_dq_oe,
  input  logic [`ROM_DW-1:0]      rom_dq_in,
  // Read data
  output logic [`DATA_W-1:0]      rd_byte,
  output logic [`DATA_W-1:0]      snes_rdata
);

  cart_pkg::rom_addr_u snes_rom_addr;
  cart_pkg::rom_addr_u sel_addr;
  logic                mcu_hit;
  logic                wr_hit;
  logic [`DATA_W-1:0]  lane_byte;

  assign wr_hit  = (state == cart_pkg::mcu_wr_addr);
  assign mcu_hit = wr_hit | (state == cart_pkg::mcu_rd_addr);

  ////////////////////////////////////////////////////////////////////////////
  // Address mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    snes_rom_addr.flat = snes_addr & rom_mask;  // ROM image mirrors by mask
    sel_addr           = mcu_hit ? req_addr : snes_rom_addr;
  end

  assign rom_addr  = sel_addr.wl.word;
  assign rom_bhe_n = sel_addr.wl.lane;   // Odd byte sits in the low lane
  assign rom_ble_n = ~sel_addr.wl.lane;

  ////////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////////

  // Strobe held low over the whole write window
  assign rom_we_n  = ~wr_hit;
  assign rom_dq_oe = wr_hit;

  always_comb begin
    if (sel_addr.wl.lane) begin
      rom_dq_out = {{`DATA_W{1'b0}}, req_wdata};
    end else begin
      rom_dq_out = {req_wdata, {`DATA_W{1'b0}}};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read path
  ////////////////////////////////////////////////////////////////////////////

  assign lane_byte = sel_addr.wl.lane ? rom_dq_in[`DATA_W-1:0]
                                      : rom_dq_in[`ROM_DW-1:`DATA_W];

  assign rd_byte    = lane_byte;
  assign snes_rdata = lane_byte;  // Only meaningful while idle

endmodule

// File: snes_bus_sync.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module snes_bus_sync (
  input  logic CLK2,
  input  logic arst_n,
  input  logic snes_cpu_clk,
  output logic cycle_start,
  output logic cycle_end,
  output logic cpu_clk_change,
  output logic snes_dead
);

  logic [`CPU_SYNC_LEN-1:0] cpu_clk_sr;
  logic [17:0]              dead_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // CPU clock synchronizer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      cpu_clk_sr <= '0;
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[`CPU_SYNC_LEN-2:0], snes_cpu_clk};
    end
  end

  // Edges are decoded past the first stage, which may still be metastable.
  // A rising CPU clock opens a bus cycle, a falling one closes it.
  assign cycle_start    = (cpu_clk_sr[4:1] == 4'b0001);
  assign cycle_end      = (cpu_clk_sr[4:1] == 4'b1110);
  assign cpu_clk_change = cpu_clk_sr[2] ^ cpu_clk_sr[1];

  ////////////////////////////////////////////////////////////////////////////
  // Dead console watchdog
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      dead_cnt <= '0;
    end else if (cpu_clk_change) begin
      dead_cnt <= '0;
    end else if (dead_cnt <= `SNES_DEAD_TIMEOUT) begin
      dead_cnt <= dead_cnt + 1'b1;  // Saturates just past timeout
    end
  end

  // No console clock seen yet after reset
  always_ff @(posedge CLK2 or negedge arst_n) begin
    if (!arst_n) begin
      snes_dead <= 1'b1;
    end else if (cpu_clk_change) begin
      snes_dead <= 1'b0;  // Console woke up
    end else if (dead_cnt > `SNES_DEAD_TIMEOUT) begin
      snes_dead <= 1'b1;
    end
  end

endmodule

// File: tb_cart_main.sv
`timescale 1ns/1ps
`include "cart_consts.svh"

module tb_cart_main;

  localparam int N_TRANS   = 67;    // MCU accesses over all phases
  localparam int MEM_WORDS = 4096;  // PSRAM window the test uses
  localparam int WATCHDOG_CYCLES =
    N_TRANS * (`SNES_DEAD_TIMEOUT + 200) + 2 * `SNES_DEAD_TIMEOUT;

  logic                    CLK2;
  logic                    arst_n;
  logic                    snes_cpu_clk;
  logic [`ROM_AW-1:0]      snes_addr;
  logic                    snes_romsel_n;
  logic [`ROM_AW-1:0]      rom_mask;
  logic [`DATA_W-1:0]      snes_rdata;
  logic                    mcu_req;
  logic                    mcu_we;
  cart_pkg::rom_addr_u     mcu_addr;
  logic [`DATA_W-1:0]      mcu_wdata;
  logic                    mcu_ack;
  logic [`DATA_W-1:0]      mcu_rdata;
  logic [`ROM_WORD_AW-1:0] rom_addr;
  logic                    rom_bhe_n;
  logic                    rom_ble_n;
  logic                    rom_we_n;
  logic [`ROM_DW-1:0]      rom_dq_out;
  logic                    rom_dq_oe;
  logic [`ROM_DW-1:0]      rom_dq_in;

  logic [`ROM_DW-1:0] psram   [0:MEM_WORDS-1];
  logic [`DATA_W-1:0] ref_mem [0:2*MEM_WORDS-1];  // Expected byte per address
  logic [12:0]        wr_list [0:23];
  logic [31:0]        rng_state;
  logic               cpu_run;
  int                 cpu_half;
  int                 cpu_cnt;
  logic               prev_req;
  logic               prev_ack;

  cart_main dut_i (
    .CLK2          (CLK2),
    .arst_n        (arst_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_addr     (snes_addr),
    .snes_romsel_n (snes_romsel_n),
    .rom_mask      (rom_mask),
    .snes_rdata    (snes_rdata),
    .mcu_req       (mcu_req),
    .mcu_we        (mcu_we),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .mcu_ack       (mcu_ack),
    .mcu_rdata     (mcu_rdata),
    .rom_addr      (rom_addr),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .rom_we_n      (rom_we_n),
    .rom_dq_out    (rom_dq_out),
    .rom_dq_oe     (rom_dq_oe),
    .rom_dq_in     (rom_dq_in)
  );

  always #20 CLK2 = ~CLK2;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return {16'h0, rng_state[31:16]};  // Upper bits are the better ones
  endfunction

  // Initial PSRAM contents depend on every word address bit
  function automatic logic [`ROM_DW-1:0] fill_word(input logic [11:0] w);
    return {w[3:0], w[11:0]} ^ 16'hA53C;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got %b, expected %b", $time, what, act, exp));
    end
  endtask

  task automatic check_byte(input logic [`DATA_W-1:0] act, input logic [`DATA_W-1:0] exp,
                            input string what);
    if (act !== exp) begin
      fail_run($sformatf("ERROR at %0t: %s got %h, expected %h", $time, what, act, exp));
    end
  endtask

  task automatic check_addr(input cart_pkg::rom_addr_u act, input cart_pkg::rom_addr_u exp,
                            input string what);
    if (act.flat !== exp.flat) begin
      fail_run($sformatf("ERROR at %0t: %s got %h, expected %h",
                         $time, what, act.flat, exp.flat));
    end
  endtask

  // Both lanes of the PSRAM word against the model
  task automatic check_word(input logic [12:0] addr);
    logic [11:0] w;
    w = addr[12:1];
    check_byte(psram[w][15:8], ref_mem[{w, 1'b0}], "PSRAM high lane");
    check_byte(psram[w][7:0], ref_mem[{w, 1'b1}], "PSRAM low lane");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // MCU handshake
  ////////////////////////////////////////////////////////////////////////////

  task automatic mcu_start(input logic we, input logic [12:0] addr,
                           input logic [`DATA_W-1:0] data);
    @(negedge CLK2);
    mcu_we        = we;
    mcu_addr.flat = {11'b0, addr};
    mcu_wdata     = data;
    mcu_req       = 1'b1;
  endtask

  task automatic mcu_finish(output logic [`DATA_W-1:0] rdata);
    @(negedge CLK2);
    while (!mcu_ack) @(negedge CLK2);
    rdata   = mcu_rdata;
    mcu_req = 1'b0;
    @(negedge CLK2);
    while (mcu_ack) @(negedge CLK2);
  endtask

  task automatic mcu_write(input logic [12:0] addr, input logic [`DATA_W-1:0] data);
    logic [`DATA_W-1:0] rd;
    ref_mem[addr] = data;
    mcu_start(1'b1, addr, data);
    mcu_finish(rd);
    check_word(addr);
  endtask

  task automatic mcu_read(input logic [12:0] addr);
    logic [`DATA_W-1:0] rd;
    mcu_start(1'b0, addr, 8'h00);
    mcu_finish(rd);
    check_byte(rd, ref_mem[addr], "MCU read data");
  endtask

  // Console reads the masked address while the arbiter is idle
  task automatic snes_check();
    logic [31:0]         r1;
    logic [31:0]         r2;
    cart_pkg::rom_addr_u exp_a;
    cart_pkg::rom_addr_u act_a;
    r1 = next_rand();
    r2 = next_rand();
    @(negedge CLK2);
    snes_addr  = {r1[7:0], r2[15:0]};
    exp_a.flat = snes_addr & rom_mask;
    @(negedge CLK2);
    act_a.wl.word = rom_addr;
    act_a.wl.lane = ~rom_ble_n;
    check_addr(act_a, exp_a, "ROM address for SNES");
    check_bit(rom_bhe_n, exp_a.wl.lane, "rom_bhe_n for SNES");
    check_byte(snes_rdata, ref_mem[exp_a.flat[12:0]], "SNES read data");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Console clock, PSRAM model, monitors
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge CLK2) begin
    if (cpu_run) begin
      if (cpu_cnt == 0) begin
        snes_cpu_clk = ~snes_cpu_clk;
        if (snes_cpu_clk) begin
          snes_romsel_n = ~snes_romsel_n;  // Every other cycle leaves ROM free
        end
        cpu_cnt = cpu_half;
      end else begin
        cpu_cnt = cpu_cnt - 1;
      end
    end
  end

  assign rom_dq_in = psram[rom_addr[11:0]];

  always @(posedge CLK2) begin
    if (arst_n && !rom_we_n) begin
      if (!rom_dq_oe) begin
        fail_run("PSRAM write strobe is active while the data bus is not driven");
      end
      if (!rom_bhe_n) begin
        psram[rom_addr[11:0]][15:8] <= rom_dq_out[15:8];
      end
      if (!rom_ble_n) begin
        psram[rom_addr[11:0]][7:0] <= rom_dq_out[7:0];
      end
    end
  end

  // Four-phase rules against the values of the previous edge
  always @(posedge CLK2) begin
    if (arst_n) begin
      if (mcu_ack && !prev_ack && !prev_req) begin
        fail_run("mcu_ack rose while mcu_req was low");
      end
      if (!mcu_ack && prev_ack && prev_req) begin
        fail_run("mcu_ack fell before mcu_req was released");
      end
    end
    prev_req = mcu_req;
    prev_ack = mcu_ack;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK2);
    fail_run("Timeout: the test did not finish within the expected number of cycles");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0]        r;
    logic [12:0]        a;
    logic [`DATA_W-1:0] rd;
    CLK2          = 1'b0;
    arst_n        = 1'b0;
    snes_cpu_clk  = 1'b0;
    snes_addr     = '0;
    snes_romsel_n = 1'b1;
    rom_mask      = 24'h001FFF;
    mcu_req       = 1'b0;
    mcu_we        = 1'b0;
    mcu_addr      = '0;
    mcu_wdata     = '0;
    rng_state     = 32'd18219;
    cpu_run       = 1'b0;
    cpu_cnt       = 0;
    cpu_half      = 10;
    prev_req      = 1'b0;
    prev_ack      = 1'b0;
    for (int w = 0; w < MEM_WORDS; w++) begin
      psram[w]         = fill_word(w[11:0]);
      ref_mem[2*w]     = psram[w][15:8];  // Even byte in the high lane
      ref_mem[2*w + 1] = psram[w][7:0];
    end

    repeat (10) @(negedge CLK2);
    arst_n = 1'b1;
    @(negedge CLK2);
    check_bit(mcu_ack, 1'b0, "mcu_ack after reset");
    check_bit(rom_we_n, 1'b1, "rom_we_n after reset");
    check_bit(rom_dq_oe, 1'b0, "rom_dq_oe after reset");

    // Console dead since reset so accesses run freely
    for (int i = 0; i < 24; i++) begin
      r          = next_rand();
      wr_list[i] = r[12:0];
      r          = next_rand();
      mcu_write(wr_list[i], r[7:0]);
    end
    for (int i = 0; i < 24; i++) begin
      mcu_read(wr_list[(i * 7) % 24]);
    end

    // Live console at a random slow rate
    r        = next_rand();
    cpu_half = 6 + (r % 16);
    @(posedge CLK2);
    cpu_run  = 1'b1;
    for (int i = 0; i < 16; i++) begin
      if (i % 4 == 0) begin
        r = next_rand();
        @(negedge CLK2);
        rom_mask = 24'h001FFF >> (r % 3);
      end
      repeat (4) snes_check();
      r = next_rand();
      a = r[12:0];
      r = next_rand();
      if (i % 2 == 1) begin
        mcu_read(a);
      end else begin
        mcu_write(a, r[7:0]);
      end
    end

    // Console wakes up in the middle of a free-running access
    r = next_rand();
    a = r[12:0];
    for (int k = 0; k < 2; k++) begin
      @(posedge CLK2);
      cpu_run = 1'b0;
      repeat (`SNES_DEAD_TIMEOUT + 20) @(negedge CLK2);
      r = next_rand();
      if (k == 0) begin
        ref_mem[a] = r[7:0];
        mcu_start(1'b1, a, r[7:0]);
      end else begin
        mcu_start(1'b0, a, 8'h00);
      end
      repeat (4) @(negedge CLK2);
      @(posedge CLK2);
      cpu_cnt = 0;
      cpu_run = 1'b1;
      mcu_finish(rd);
      if (k == 0) begin
        check_word(a);
      end else begin
        check_byte(rd, ref_mem[a], "MCU read after wake-up");
      end
    end
    mcu_read(a);

    $display("Verification passed");
    $finish;
  end

endmodule
